//--- hdl/msx_pkg.sv
package msx_pkg;

   // machine generation
   typedef enum logic {
      MSX1 = 1'b0,
      MSX2 = 1'b1
   } msx_typ_t;

   // device plugged into a cartridge slot
   typedef enum logic [2:0] {
      CART_TYP_ROM    = 3'd0,
      CART_TYP_SCC    = 3'd1,
      CART_TYP_SCC2   = 3'd2,
      CART_TYP_FM_PAC = 3'd3,
      CART_TYP_MFRSD  = 3'd4,
      CART_TYP_GM2    = 3'd5,
      CART_TYP_FDC    = 3'd6,
      CART_TYP_EMPTY  = 3'd7
   } cart_typ_t;

   typedef enum logic [3:0] {
      MAPPER_AUTO       = 4'd0,
      MAPPER_ASCII8     = 4'd1,
      MAPPER_ASCII16    = 4'd2,
      MAPPER_KONAMI     = 4'd3,
      MAPPER_KONAMI_SCC = 4'd4,
      MAPPER_KOEI       = 4'd5,
      MAPPER_LINEAR64   = 4'd6,
      MAPPER_RTYPE      = 4'd7,
      MAPPER_WIZARDRY   = 4'd8,
      MAPPER_FMPAC      = 4'd9,
      MAPPER_NONE       = 4'd10,
      MAPPER_UNUSED     = 4'd11
   } mapper_typ_t;

   typedef enum logic [1:0] {
      DEVICE_NONE = 2'd0,
      DEVICE_FDC  = 2'd1,
      DEVICE_OPL3 = 2'd2
   } device_typ_t;

   typedef enum logic [1:0] {
      ROM_NONE  = 2'd0,
      ROM_ROM   = 2'd1,
      ROM_FMPAC = 2'd2,
      ROM_FDC   = 2'd3
   } rom_typ_t;

   typedef enum logic [1:0] {
      VIDEO_AUTO = 2'd0,
      VIDEO_PAL  = 2'd1,
      VIDEO_NTSC = 2'd2
   } video_mode_t;

   typedef enum logic {
      CAS_AUDIO_FILE = 1'b0,
      CAS_AUDIO_ADC  = 1'b1
   } cas_audio_src_t;

   typedef struct packed {
      mapper_typ_t mapper;
      device_typ_t mem_device;
      device_typ_t io_device;
      rom_typ_t    rom_id;
      logic [7:0]  mode;
      logic [7:0]  param;
      logic [7:0]  sram_size;   // kB
   } config_cart_t;

   typedef struct packed {
      msx_typ_t       typ;
      video_mode_t    video_mode;
      cas_audio_src_t cas_audio_src;
      logic           scandoubler;
      logic           border;
   } user_config_t;

   // raw menu choices that force a machine reset when changed
   typedef struct packed {
      cart_typ_t  cart_typ_b;
      cart_typ_t  cart_typ_a;
      logic [3:0] mapper_a_sel;
      logic [3:0] mapper_b_sel;
      logic [2:0] sram_a_sel;
   } slot_select_t;

   // bit positions inside the host status word
   localparam int ST_CAS_AUDIO  = 8;
   localparam int ST_MSX_TYP    = 11;
   localparam int ST_VIDEO_MSX1 = 12;
   localparam int ST_VIDEO_LO   = 13;
   localparam int ST_SLOT_A_LO  = 17;
   localparam int ST_MAPPER_A_LO = 20;
   localparam int ST_SRAM_A_LO  = 26;
   localparam int ST_SLOT_B_LO  = 29;
   localparam int ST_MAPPER_B_LO = 32;
   localparam int ST_BORDER     = 38;

endpackage

//--- hdl/status_port.sv
module status_port (
   input  logic        clk,
   input  logic        reset,
   input  logic        req,
   input  logic [63:0] status_word,
   output logic        ack,
   output logic [63:0] status,
   output logic        load
);

   logic take;
   logic release_ack;

   // req up while ack still down starts a transfer
   assign take = req && !ack;
   // host has seen ack and dropped req
   assign release_ack = !req && ack;

   always_ff @(posedge clk) begin
      if (reset) begin
         ack <= 1'b0;
         load <= 1'b0;
      end else begin
         load <= take;
         if (take) begin
            ack <= 1'b1;
         end else if (release_ack) begin
            ack <= 1'b0;
         end
      end
   end

   // current menu word
   always_ff @(posedge clk) begin
      if (reset) begin
         status <= '0;
      end else if (take) begin
         status <= status_word;
      end
   end

endmodule

//--- hdl/cart_conf.sv
module cart_conf import msx_pkg::*; (
   input  cart_typ_t    typ,
   input  mapper_typ_t  selected_mapper,
   input  logic [7:0]   selected_sram_size,
   output config_cart_t config_cart
);

   always_comb begin
      // default covers SCC, SCC2, MFRSD and EMPTY
      config_cart.mapper = MAPPER_UNUSED;
      config_cart.mem_device = DEVICE_NONE;
      config_cart.io_device = DEVICE_NONE;
      config_cart.rom_id = ROM_NONE;
      config_cart.mode = 8'h00;
      config_cart.param = 8'h00;
      config_cart.sram_size = 8'd0;
      case (typ)
         CART_TYP_ROM: begin
            config_cart.mapper = selected_mapper;
            config_cart.rom_id = ROM_ROM;
            config_cart.mode = 8'hAA;
            config_cart.param = 8'hE4;
            config_cart.sram_size = selected_sram_size;
         end
         CART_TYP_FM_PAC: begin
            config_cart.mapper = MAPPER_FMPAC;
            config_cart.io_device = DEVICE_OPL3;
            config_cart.rom_id = ROM_FMPAC;
            config_cart.mode = 8'h08;
            config_cart.sram_size = 8'd8;
         end
         CART_TYP_GM2: begin
            config_cart.sram_size = 8'd8;
         end
         CART_TYP_FDC: begin
            config_cart.mapper = MAPPER_NONE;
            config_cart.mem_device = DEVICE_FDC;
            config_cart.rom_id = ROM_FDC;
            config_cart.mode = 8'h08;
         end
         default: begin
         end
      endcase
   end

endmodule

//--- hdl/msx_config.sv
module msx_config import msx_pkg::*; (
   input  logic                  [63:0] status,
   input  logic                         scandoubler,
   output config_cart_t          [1:0]  cart_conf,
   output logic            [1:0] [2:0]  sram_size,
   output user_config_t                 msx_config,
   output slot_select_t                 selection,
   output logic                         sram_a_select_hide,
   output logic                         sram_loadsave_hide,
   output logic                         rom_a_load_hide,
   output logic                         rom_b_load_hide,
   output logic                         fdc_enabled
);

   msx_typ_t    msx_typ;
   cart_typ_t   cart_typ_a;
   cart_typ_t   cart_typ_b;
   mapper_typ_t mapper_a;
   mapper_typ_t mapper_b;
   logic [2:0]  slot_a_sel;
   logic [2:0]  slot_b_sel;
   logic [3:0]  mapper_a_sel;
   logic [3:0]  mapper_b_sel;
   logic [2:0]  sram_a_sel;
   logic [2:0]  sram_a_code;
   logic [7:0]  sram_a_kb;

   assign msx_typ = msx_typ_t'(status[ST_MSX_TYP]);
   assign slot_a_sel = status[ST_SLOT_A_LO +: 3];
   assign slot_b_sel = status[ST_SLOT_B_LO +: 3];
   assign mapper_a_sel = status[ST_MAPPER_A_LO +: 4];
   assign mapper_b_sel = status[ST_MAPPER_B_LO +: 4];
   assign sram_a_sel = status[ST_SRAM_A_LO +: 3];

   // code 6 is the FDC only on MSX1, MSX2 has it built in
   assign cart_typ_a = (slot_a_sel < 3'd6) ? cart_typ_t'(slot_a_sel) :
                       (slot_a_sel == 3'd6 && msx_typ == MSX1) ? CART_TYP_FDC :
                       CART_TYP_EMPTY;
   assign cart_typ_b = (slot_b_sel < 3'd4) ? cart_typ_t'(slot_b_sel) : CART_TYP_EMPTY;

   // menu list starts at auto, so shift by one
   assign mapper_a = (mapper_a_sel >= 4'd9) ? MAPPER_UNUSED :
                     mapper_typ_t'(mapper_a_sel + 4'd1);
   assign mapper_b = (mapper_b_sel >= 4'd9) ? MAPPER_UNUSED :
                     mapper_typ_t'(mapper_b_sel + 4'd1);

   assign sram_a_select_hide = (cart_typ_a != CART_TYP_ROM) || (mapper_a_sel == 4'd0);
   assign sram_a_code = (sram_a_select_hide || sram_a_sel == 3'd7) ? 3'd0 : sram_a_sel;

   always_comb begin
      case (sram_a_code)
         3'd1: sram_a_kb = 8'd1;
         3'd2: sram_a_kb = 8'd2;
         3'd3: sram_a_kb = 8'd4;
         3'd4: sram_a_kb = 8'd8;
         3'd5: sram_a_kb = 8'd16;
         3'd6: sram_a_kb = 8'd32;
         default: sram_a_kb = 8'd0;
      endcase
   end

   assign sram_size[0] = sram_a_code;
   assign sram_size[1] = 3'd0;

   assign msx_config.typ = msx_typ;
   assign msx_config.video_mode = (msx_typ == MSX1) ?
                                  (status[ST_VIDEO_MSX1] ? VIDEO_NTSC : VIDEO_PAL) :
                                  video_mode_t'(status[ST_VIDEO_LO +: 2]);
   assign msx_config.cas_audio_src = cas_audio_src_t'(status[ST_CAS_AUDIO]);
   assign msx_config.scandoubler = scandoubler;
   assign msx_config.border = status[ST_BORDER];

   assign sram_loadsave_hide = (sram_size[0] == 3'd0) && (sram_size[1] == 3'd0);
   assign rom_a_load_hide = cart_typ_a != CART_TYP_ROM;
   assign rom_b_load_hide = cart_typ_b != CART_TYP_ROM;
   assign fdc_enabled = (msx_typ == MSX2) || (cart_typ_a == CART_TYP_FDC);

   assign selection.cart_typ_b = cart_typ_b;
   assign selection.cart_typ_a = cart_typ_a;
   assign selection.mapper_a_sel = mapper_a_sel;
   assign selection.mapper_b_sel = mapper_b_sel;
   assign selection.sram_a_sel = sram_a_sel;

   cart_conf conf_a (
      .typ                (cart_typ_a),
      .selected_mapper    (mapper_a),
      .selected_sram_size (sram_a_kb),
      .config_cart        (cart_conf[0])
   );

   // slot B carries no SRAM
   cart_conf conf_b (
      .typ                (cart_typ_b),
      .selected_mapper    (mapper_b),
      .selected_sram_size (8'd0),
      .config_cart        (cart_conf[1])
   );

endmodule

//--- hdl/config_monitor.sv
module config_monitor import msx_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  logic         load,
   input  slot_select_t selection,
   output logic         reset_request,
   output logic         cart_changed
);

   logic         armed;
   slot_select_t baseline;
   cart_typ_t    prev_typ_a;
   cart_typ_t    prev_typ_b;
   logic         typ_differs;

   assign typ_differs = (selection.cart_typ_a != prev_typ_a) ||
                        (selection.cart_typ_b != prev_typ_b);

   always_ff @(posedge clk) begin
      if (reset) begin
         armed <= 1'b0;
         reset_request <= 1'b0;
         cart_changed <= 1'b0;
      end else begin
         cart_changed <= load && armed && typ_differs;
         if (load) begin
            armed <= 1'b1;
            // sticky until the core is reset
            if (armed && selection != baseline) begin
               reset_request <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load && !armed) begin
         baseline <= selection;
      end
      if (load) begin
         prev_typ_a <= selection.cart_typ_a;
         prev_typ_b <= selection.cart_typ_b;
      end
   end

endmodule

//--- hdl/msx_config_top.sv
module msx_config_top import msx_pkg::*; (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        req,
   input  logic                 [63:0] status_word,
   input  logic                        scandoubler,
   output logic                        ack,
   output config_cart_t         [1:0]  cart_conf,
   output logic           [1:0] [2:0]  sram_size,
   output user_config_t                msx_config,
   output logic                        sram_a_select_hide,
   output logic                        sram_loadsave_hide,
   output logic                        rom_a_load_hide,
   output logic                        rom_b_load_hide,
   output logic                        fdc_enabled,
   output logic                        reset_request,
   output logic                        cart_changed
);

   logic  [63:0] status;
   logic         load;
   slot_select_t selection;

   status_port i_status_port (
      .clk         (clk),
      .reset       (reset),
      .req         (req),
      .status_word (status_word),
      .ack         (ack),
      .status      (status),
      .load        (load)
   );

   msx_config i_msx_config (
      .status             (status),
      .scandoubler        (scandoubler),
      .cart_conf          (cart_conf),
      .sram_size          (sram_size),
      .msx_config         (msx_config),
      .selection          (selection),
      .sram_a_select_hide (sram_a_select_hide),
      .sram_loadsave_hide (sram_loadsave_hide),
      .rom_a_load_hide    (rom_a_load_hide),
      .rom_b_load_hide    (rom_b_load_hide),
      .fdc_enabled        (fdc_enabled)
   );

   config_monitor i_config_monitor (
      .clk           (clk),
      .reset         (reset),
      .load          (load),
      .selection     (selection),
      .reset_request (reset_request),
      .cart_changed  (cart_changed)
   );

endmodule

//--- tb/tb_msx_config_top.sv
module tb_msx_config_top import msx_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_ROWS = 13;
   localparam int CYCLE_LIMIT = NUM_ROWS * 12 + 50;
   // bits 8, 14:11, 23:17, 35:26 and 38 carry menu fields
   localparam logic [63:0] USED_BITS = 64'h0000_004f_fcfe_7900;

   // descriptors of the slot types with a fixed entry
   localparam config_cart_t CONF_NONE =
      '{MAPPER_UNUSED, DEVICE_NONE, DEVICE_NONE, ROM_NONE, 8'h00, 8'h00, 8'd0};
   localparam config_cart_t CONF_FM_PAC =
      '{MAPPER_FMPAC, DEVICE_NONE, DEVICE_OPL3, ROM_FMPAC, 8'h08, 8'h00, 8'd8};
   localparam config_cart_t CONF_GM2 =
      '{MAPPER_UNUSED, DEVICE_NONE, DEVICE_NONE, ROM_NONE, 8'h00, 8'h00, 8'd8};
   localparam config_cart_t CONF_FDC =
      '{MAPPER_NONE, DEVICE_FDC, DEVICE_NONE, ROM_FDC, 8'h08, 8'h00, 8'd0};

   typedef struct packed {
      logic         pre_reset;
      logic [63:0]  word;
      logic         scan;
      cart_typ_t    typ_a;
      cart_typ_t    typ_b;
      config_cart_t conf_a;
      config_cart_t conf_b;
      logic [2:0]   sram_a;
      video_mode_t  video;
      logic [2:0]   flags;   // sram_a_select_hide, sram_loadsave_hide, fdc_enabled
      logic [1:0]   mon;     // reset_request, cart_changed
   } row_t;

   logic                clk;
   logic                reset;
   logic                req;
   logic         [63:0] status_word;
   logic                scandoubler;
   logic                ack;
   config_cart_t [1:0]  cart_conf;
   logic   [1:0] [2:0]  sram_size;
   user_config_t        msx_config;
   logic                sram_a_select_hide;
   logic                sram_loadsave_hide;
   logic                rom_a_load_hide;
   logic                rom_b_load_hide;
   logic                fdc_enabled;
   logic                reset_request;
   logic                cart_changed;

   row_t   rows [NUM_ROWS];
   integer seed;
   int     errors = 0;
   int     cycles = 0;

   msx_config_top i_msx_config_top (.*);

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: transfers did not complete within %0d cycles", CYCLE_LIMIT);
         $display("Testbench failed");
         $fatal(1);
      end
   end

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         $display("Testbench failed");
         $fatal(1);
      end
   endtask

   function automatic logic [63:0] status_bits(input logic msx2, input logic [2:0] vid,
         input logic cas, input logic [2:0] sa, input logic [3:0] ma, input logic [2:0] sr,
         input logic [2:0] sb, input logic [3:0] mb, input logic border);
      return {25'd0, border, 2'b00, mb, sb, sr, 2'b00, ma, sa, 2'b00, vid, msx2, 2'b00,
              cas, 8'h00};
   endfunction

   // ROM slot entry with its mapper and SRAM size
   function automatic config_cart_t rom_descriptor(input mapper_typ_t mapper,
                                                   input logic [7:0] kb);
      return '{mapper, DEVICE_NONE, DEVICE_NONE, ROM_ROM, 8'hAA, 8'hE4, kb};
   endfunction

   task automatic fill_table();
      rows[0] = '{1'b0, status_bits(1'b0, 3'b001, 1'b1, 3'd0, 4'd2, 3'd3, 3'd1, 4'd0, 1'b1),
         1'b0, CART_TYP_ROM, CART_TYP_SCC, rom_descriptor(MAPPER_KONAMI, 8'd4),
         CONF_NONE, 3'd3, VIDEO_NTSC, 3'b000, 2'b00};
      // only video, audio, border and scandoubler change
      rows[1] = '{1'b0, status_bits(1'b0, 3'b000, 1'b0, 3'd0, 4'd2, 3'd3, 3'd1, 4'd0, 1'b0),
         1'b1, CART_TYP_ROM, CART_TYP_SCC, rom_descriptor(MAPPER_KONAMI, 8'd4),
         CONF_NONE, 3'd3, VIDEO_PAL, 3'b000, 2'b00};
      rows[2] = '{1'b0, status_bits(1'b0, 3'b001, 1'b1, 3'd0, 4'd9, 3'd3, 3'd1, 4'd0, 1'b1),
         1'b0, CART_TYP_ROM, CART_TYP_SCC, rom_descriptor(MAPPER_UNUSED, 8'd4),
         CONF_NONE, 3'd3, VIDEO_NTSC, 3'b000, 2'b10};
      rows[3] = '{1'b0, status_bits(1'b0, 3'b001, 1'b0, 3'd3, 4'd9, 3'd3, 3'd2, 4'd15, 1'b0),
         1'b0, CART_TYP_FM_PAC, CART_TYP_SCC2, CONF_FM_PAC,
         CONF_NONE, 3'd0, VIDEO_NTSC, 3'b110, 2'b11};
      rows[4] = '{1'b0, status_bits(1'b0, 3'b000, 1'b0, 3'd6, 4'd0, 3'd5, 3'd3, 4'd4, 1'b0),
         1'b1, CART_TYP_FDC, CART_TYP_FM_PAC, CONF_FDC,
         CONF_FM_PAC, 3'd0, VIDEO_PAL, 3'b111, 2'b11};
      // new baseline after reset
      // MSX2 turns code 6 into an empty slot
      rows[5] = '{1'b1, status_bits(1'b1, 3'b100, 1'b1, 3'd6, 4'd1, 3'd2, 3'd4, 4'd8, 1'b1),
         1'b0, CART_TYP_EMPTY, CART_TYP_EMPTY, CONF_NONE,
         CONF_NONE, 3'd0, VIDEO_NTSC, 3'b111, 2'b00};
      rows[6] = '{1'b0, status_bits(1'b1, 3'b011, 1'b0, 3'd6, 4'd1, 3'd2, 3'd7, 4'd8, 1'b0),
         1'b1, CART_TYP_EMPTY, CART_TYP_EMPTY, CONF_NONE,
         CONF_NONE, 3'd0, VIDEO_PAL, 3'b111, 2'b00};
      rows[7] = '{1'b0, status_bits(1'b1, 3'b000, 1'b0, 3'd5, 4'd1, 3'd2, 3'd0, 4'd7, 1'b0),
         1'b0, CART_TYP_GM2, CART_TYP_ROM, CONF_GM2,
         rom_descriptor(MAPPER_WIZARDRY, 8'd0), 3'd0, VIDEO_AUTO, 3'b111, 2'b11};
      rows[8] = '{1'b0, status_bits(1'b1, 3'b000, 1'b0, 3'd4, 4'd1, 3'd2, 3'd0, 4'd9, 1'b0),
         1'b0, CART_TYP_MFRSD, CART_TYP_ROM, CONF_NONE,
         rom_descriptor(MAPPER_UNUSED, 8'd0), 3'd0, VIDEO_AUTO, 3'b111, 2'b11};
      rows[9] = '{1'b0, status_bits(1'b1, 3'b100, 1'b0, 3'd0, 4'd0, 3'd6, 3'd0, 4'd5, 1'b0),
         1'b0, CART_TYP_ROM, CART_TYP_ROM, rom_descriptor(MAPPER_ASCII8, 8'd0),
         rom_descriptor(MAPPER_LINEAR64, 8'd0), 3'd0, VIDEO_NTSC, 3'b111, 2'b11};
      rows[10] = '{1'b0, status_bits(1'b1, 3'b100, 1'b1, 3'd0, 4'd4, 3'd6, 3'd0, 4'd5, 1'b1),
         1'b0, CART_TYP_ROM, CART_TYP_ROM, rom_descriptor(MAPPER_KOEI, 8'd32),
         rom_descriptor(MAPPER_LINEAR64, 8'd0), 3'd6, VIDEO_NTSC, 3'b001, 2'b10};
      rows[11] = '{1'b0, status_bits(1'b0, 3'b000, 1'b0, 3'd0, 4'd8, 3'd7, 3'd1, 4'd3, 1'b0),
         1'b1, CART_TYP_ROM, CART_TYP_SCC, rom_descriptor(MAPPER_FMPAC, 8'd0),
         CONF_NONE, 3'd0, VIDEO_PAL, 3'b010, 2'b11};
      // back to the baseline choices
      // reset request must stay set
      rows[12] = '{1'b0, status_bits(1'b1, 3'b001, 1'b0, 3'd6, 4'd1, 3'd2, 3'd5, 4'd8, 1'b1),
         1'b0, CART_TYP_EMPTY, CART_TYP_EMPTY, CONF_NONE,
         CONF_NONE, 3'd0, VIDEO_AUTO, 3'b111, 2'b11};
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (5) @(posedge clk);
      #2;
      reset = 1'b0;
      check_value("ack", ack, 1'b0);
      check_value("reset_request", reset_request, 1'b0);
      check_value("cart_changed", cart_changed, 1'b0);
   endtask

   task automatic send_row(input int i);
      logic [63:0] noise;
      noise = {$random(seed), $random(seed)};
      if (rows[i].pre_reset) begin
         apply_reset();
      end
      check_value("ack", ack, 1'b0);
      status_word = rows[i].word | (noise & ~USED_BITS);
      scandoubler = rows[i].scan;
      req = 1'b1;
      do begin
         @(posedge clk);
         #2;
      end while (!ack);
      // monitor flags follow one cycle after the load
      @(posedge clk);
      #2;
      check_value("ack", ack, 1'b1);
      check_value("cart_conf[0]", cart_conf[0], rows[i].conf_a);
      check_value("cart_conf[1]", cart_conf[1], rows[i].conf_b);
      check_value("sram_size[0]", sram_size[0], rows[i].sram_a);
      check_value("sram_size[1]", sram_size[1], 3'd0);
      check_value("msx_config.typ", msx_config.typ, rows[i].word[11]);
      check_value("msx_config.video_mode", msx_config.video_mode, rows[i].video);
      check_value("msx_config.cas_audio_src", msx_config.cas_audio_src, rows[i].word[8]);
      check_value("msx_config.scandoubler", msx_config.scandoubler, rows[i].scan);
      check_value("msx_config.border", msx_config.border, rows[i].word[38]);
      check_value("hide_flags", {sram_a_select_hide, sram_loadsave_hide, fdc_enabled},
                  rows[i].flags);
      check_value("rom_a_load_hide", rom_a_load_hide, rows[i].typ_a != CART_TYP_ROM);
      check_value("rom_b_load_hide", rom_b_load_hide, rows[i].typ_b != CART_TYP_ROM);
      check_value("reset_request", reset_request, rows[i].mon[1]);
      check_value("cart_changed", cart_changed, rows[i].mon[0]);
      req = 1'b0;
      do begin
         @(posedge clk);
         #2;
      end while (ack);
      check_value("cart_changed", cart_changed, 1'b0);
   endtask

   initial begin
      seed = 32'hde937fc4;
      clk = 1'b0;
      reset = 1'b1;
      req = 1'b0;
      status_word = 64'h0;
      scandoubler = 1'b0;
      fill_table();
      apply_reset();
      // no req yet, so no ack either
      repeat (3) begin
         @(posedge clk);
         #2;
         check_value("ack", ack, 1'b0);
      end
      for (int i = 0; i < NUM_ROWS; i++) begin
         send_row(i);
      end
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- sources.f
hdl/msx_pkg.sv
hdl/status_port.sv
hdl/cart_conf.sv
hdl/msx_config.sv
hdl/config_monitor.sv
hdl/msx_config_top.sv
tb/tb_msx_config_top.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --timing
SIM_FLAGS = --binary -Wno-fatal
TOP       = tb_msx_config_top
RTL_TOP   = msx_config_top
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Testbench passed

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(TOOL) $(SIM_FLAGS) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
